// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cache_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory $(OBJ_DIR)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR, TOP, OBJ_DIR, VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f vlog.f --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== src/cache.sv ====
`timescale 1ns/1ns
`include "cache_defs.svh"

// two-way write-back cache, controller plus datapath
module cache (
    input  logic                  clk,
    input  logic                  rst,
    // cpu side
    input  logic                  cpu_request,
    input  logic                  cpu_rw,
    input  logic [`ADDR_BITS-1:0] cpu_addr,
    input  cache_pkg::word_t      cpu_wdata,
    output cache_pkg::word_t      cpu_rdata,
    output logic                  cpu_response,
    // memory side
    output logic                  memory_request,
    output logic                  memory_rw,
    output cache_pkg::mem_xfer_t  mem_out,
    input  logic                  memory_response,
    input  cache_pkg::line_t      memory_rdata
);

    import cache_pkg::*;

    cpu_req_t   cpu_req;
    dp_ctrl_t   ctrl;
    dp_status_t status;

    // cpu ports bundled, held steady by the cpu
    always_comb begin
        cpu_req.addr  = cpu_addr;
        cpu_req.rw    = cpu_rw;
        cpu_req.wdata = cpu_wdata;
    end

    cache_control u_control (
        .clk             (clk),
        .rst             (rst),
        .status          (status),
        .cpu_request     (cpu_request),
        .cpu_rw          (cpu_req.rw),
        .memory_response (memory_response),
        .ctrl            (ctrl),
        .cpu_response    (cpu_response),
        .memory_request  (memory_request),
        .memory_rw       (memory_rw)
    );

    cache_datapath u_datapath (
        .clk          (clk),
        .rst          (rst),
        .cpu_req      (cpu_req),
        .ctrl         (ctrl),
        .memory_rdata (memory_rdata),
        .status       (status),
        .cpu_rdata    (cpu_rdata),
        .mem_out      (mem_out)
    );

endmodule

// ==== src/cache_control.sv ====
`timescale 1ns/1ns

// hit / write-back / read-in controller
// hits are served in idle with no extra cycle
module cache_control (
    input  logic                   clk,
    input  logic                   rst,
    // from datapath
    input  cache_pkg::dp_status_t  status,
    // cpu side
    input  logic                   cpu_request,
    input  logic                   cpu_rw,
    // memory side
    input  logic                   memory_response,
    // to datapath
    output cache_pkg::dp_ctrl_t    ctrl,
    output logic                   cpu_response,
    output logic                   memory_request,
    output logic                   memory_rw
);

    import cache_pkg::*;

    typedef enum logic [2:0] {
        s_idle,
        s_write_back,
        s_write_back_2,
        s_read_in,
        s_read_in_2
    } state_t;

    state_t state;
    state_t next_state;

    logic hit;

    // either way matches
    assign hit = status.hit_0 | status.hit_1;

    always_comb begin
        // inactive unless a state drives it
        ctrl           = '0;
        cpu_response   = 1'b0;
        memory_request = 1'b0;
        memory_rw      = 1'b0;

        case (state)
            s_idle: begin
                if (cpu_request && hit) begin
                    // way that hit
                    ctrl.way_sel  = status.hit_1;
                    // touched way becomes mru
                    ctrl.load_lru = 1'b1;
                    // word from cpu, only stored on a write
                    ctrl.data_source_sel = 1'b0;
                    ctrl.load     = cpu_rw;
                    cpu_response  = 1'b1;
                end
            end

            s_write_back: begin
                // victim is the lru way
                ctrl.way_sel        = status.lru;
                // address from the stored tag
                ctrl.tag_bypass_sel = 1'b0;
                memory_request      = 1'b1;
                memory_rw           = 1'b1;
            end

            s_write_back_2: begin
                // request low, keep pointing at the victim
                ctrl.way_sel = status.lru;
            end

            s_read_in: begin
                ctrl.way_sel         = status.lru;
                // address from the cpu tag
                ctrl.tag_bypass_sel  = 1'b1;
                // fill line comes from memory
                ctrl.data_source_sel = 1'b1;
                memory_request       = 1'b1;
                // line captured once memory answers
                ctrl.load            = memory_response;
                // fill counts as a use
                ctrl.load_lru        = memory_response;
            end

            s_read_in_2: begin
                ctrl.way_sel = status.lru;
            end

            default: begin
            end
        endcase
    end

    always_comb begin
        next_state = state;

        case (state)
            s_idle: begin
                // miss, pick path from victim state
                if (cpu_request && !hit) begin
                    next_state = status.dirty ? s_write_back : s_read_in;
                end
            end
            // four-phase handshake, rise then fall
            s_write_back:   if (memory_response)  next_state = s_write_back_2;
            s_write_back_2: if (!memory_response) next_state = s_read_in;
            s_read_in:      if (memory_response)  next_state = s_read_in_2;
            s_read_in_2:    if (!memory_response) next_state = s_idle;
            default:        next_state = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
        end else begin
            state <= next_state;
        end
    end

endmodule

// ==== src/cache_datapath.sv ====
`timescale 1ns/1ns
`include "cache_defs.svh"

// two-way tag and data storage, compare and muxing
module cache_datapath (
    input  logic                  clk,
    input  logic                  rst,
    // held cpu access
    input  cache_pkg::cpu_req_t   cpu_req,
    // from controller
    input  cache_pkg::dp_ctrl_t   ctrl,
    // fill line from memory
    input  cache_pkg::line_t      memory_rdata,
    // to controller
    output cache_pkg::dp_status_t status,
    // to cpu
    output cache_pkg::word_t      cpu_rdata,
    // to memory
    output cache_pkg::mem_xfer_t  mem_out
);

    import cache_pkg::*;

    localparam int SETS      = 1 << `SET_BITS;
    // byte bits inside one word
    localparam int BYTE_BITS = $clog2(`WORD_BITS / 8);

    // per-way read results
    meta_t meta_rd [2];
    line_t line_rd [2];

    // shared write data, write enable per way
    meta_t      meta_wr;
    line_t      line_wr;
    logic [1:0] way_we;

    // one lru bit per set, names the way to replace next
    logic [SETS-1:0] lru_bits;
    logic            lru_cur;

    // way picked by the controller
    meta_t sel_meta;
    line_t sel_line;
    line_t merged;

    logic [`OFFSET_BITS-BYTE_BITS-1:0] word_idx;
    logic [`TAG_BITS-1:0]              mem_tag;

    // only the selected way gets written
    assign way_we[0] = ctrl.load & ~ctrl.way_sel;
    assign way_we[1] = ctrl.load & ctrl.way_sel;

    for (genvar w = 0; w < 2; w++) begin : g_way
        // valid, dirty, tag
        set_array #(.entry_t(meta_t), .SETS(SETS)) u_meta (
            .clk      (clk),
            .rst      (rst),
            .rd_set   (cpu_req.addr.set),
            .rd_entry (meta_rd[w]),
            .we       (way_we[w]),
            .wr_set   (cpu_req.addr.set),
            .wr_entry (meta_wr)
        );

        // data lines
        set_array #(.entry_t(line_t), .SETS(SETS)) u_line (
            .clk      (clk),
            .rst      (rst),
            .rd_set   (cpu_req.addr.set),
            .rd_entry (line_rd[w]),
            .we       (way_we[w]),
            .wr_set   (cpu_req.addr.set),
            .wr_entry (line_wr)
        );
    end

    assign lru_cur  = lru_bits[cpu_req.addr.set];
    assign sel_meta = meta_rd[ctrl.way_sel];
    assign sel_line = line_rd[ctrl.way_sel];
    // word index, byte bits dropped
    assign word_idx = cpu_req.addr.offset[`OFFSET_BITS-1:BYTE_BITS];

    always_comb begin
        // tag compare per way, valid required
        status.hit_0 = meta_rd[0].valid && (meta_rd[0].tag == cpu_req.addr.tag);
        status.hit_1 = meta_rd[1].valid && (meta_rd[1].tag == cpu_req.addr.tag);
        // victim needs writing back
        status.dirty = meta_rd[lru_cur].valid && meta_rd[lru_cur].dirty;
        status.lru   = lru_cur;
    end

    // read word out of the selected line
    assign cpu_rdata = sel_line[word_idx*`WORD_BITS +: `WORD_BITS];

    always_comb begin
        // cpu word patched into the current line
        merged = sel_line;
        merged[word_idx*`WORD_BITS +: `WORD_BITS] = cpu_req.wdata;

        // memory line on a fill, merged line on a write
        line_wr = ctrl.data_source_sel ? memory_rdata : merged;

        // write leaves the line dirty, fill leaves it clean
        meta_wr.valid = 1'b1;
        meta_wr.dirty = ~ctrl.data_source_sel;
        meta_wr.tag   = cpu_req.addr.tag;
    end

    // victim tag for write-back, cpu tag for read-in
    assign mem_tag = ctrl.tag_bypass_sel ? cpu_req.addr.tag : sel_meta.tag;

    always_comb begin
        mem_out.addr.tag    = mem_tag;
        mem_out.addr.set    = cpu_req.addr.set;
        // whole-line transfers
        mem_out.addr.offset = '0;
        mem_out.line        = sel_line;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_bits <= '0;
        end else if (ctrl.load_lru) begin
            // point at the way that was not used
            lru_bits[cpu_req.addr.set] <= ~ctrl.way_sel;
        end
    end

endmodule

// ==== src/cache_defs.svh ====
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// cpu byte address width
`define ADDR_BITS 16

// one cpu data word
`define WORD_BITS 32

// words per cache line
`define LINE_WORDS 4

// 8 sets
`define SET_BITS 3

// byte offset inside a line, 16 bytes per line
`define OFFSET_BITS $clog2(`LINE_WORDS * (`WORD_BITS / 8))

// whatever is left of the address above set and offset
`define TAG_BITS (`ADDR_BITS - `SET_BITS - `OFFSET_BITS)

`endif

// ==== src/cache_pkg.sv ====
`include "cache_defs.svh"

package cache_pkg;

    // one cpu word and one whole line
    typedef logic [`WORD_BITS-1:0] word_t;
    typedef logic [`LINE_WORDS*`WORD_BITS-1:0] line_t;

    // byte address split into its fields, tag on top
    typedef struct packed {
        logic [`TAG_BITS-1:0]    tag;
        logic [`SET_BITS-1:0]    set;
        logic [`OFFSET_BITS-1:0] offset;
    } addr_t;

    // per-way tag entry
    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [`TAG_BITS-1:0] tag;
    } meta_t;

    // cpu access as held by the cpu, rw high for a write
    typedef struct packed {
        addr_t addr;
        logic  rw;
        word_t wdata;
    } cpu_req_t;

    // line address (offset zero) plus the victim line
    typedef struct packed {
        addr_t addr;
        line_t line;
    } mem_xfer_t;

    // controller to datapath
    typedef struct packed {
        logic way_sel;
        logic data_source_sel;
        logic tag_bypass_sel;
        logic load;
        logic load_lru;
    } dp_ctrl_t;

    // datapath to controller
    // dirty refers to the lru way of the addressed set
    typedef struct packed {
        logic hit_0;
        logic hit_1;
        logic dirty;
        logic lru;
    } dp_status_t;

endpackage

// ==== src/set_array.sv ====
`timescale 1ns/1ns

// one entry per set, generic payload
// combinational read, one write per clock
module set_array #(
    parameter type entry_t = logic [7:0],
    parameter int  SETS    = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    // read side
    input  logic [$clog2(SETS)-1:0] rd_set,
    output entry_t                  rd_entry,
    // write side
    input  logic                    we,
    input  logic [$clog2(SETS)-1:0] wr_set,
    input  entry_t                  wr_entry
);

    // storage, one register per set
    entry_t entries [SETS];

    // read is a plain mux on the set index
    assign rd_entry = entries[rd_set];

    always_ff @(posedge clk) begin
        if (rst) begin
            // all zero, so tag entries come up invalid
            for (int i = 0; i < SETS; i++) begin
                entries[i] <= '0;
            end
        end else if (we) begin
            // single set updated per cycle
            entries[wr_set] <= wr_entry;
        end
    end

endmodule

// ==== tests/cache_assert.sv ====
`timescale 1ns/1ns

// handshake rules on the cache ports
// bound into every cache instance
module cache_assert (
    input logic clk,
    input logic rst,
    input logic cpu_request,
    input logic cpu_response,
    input logic memory_request,
    input logic memory_response
);

    // number of rule violations seen so far
    int violations = 0;

    // request held until memory answers
    a_mem_hold: assert property (@(posedge clk) disable iff (rst)
        memory_request && !memory_response |=> memory_request)
        else begin
            $error("memory_request dropped before memory_response rose");
            violations++;
        end

    // no answer without a request
    a_resp_req: assert property (@(posedge clk) disable iff (rst)
        cpu_response |-> cpu_request)
        else begin
            $error("cpu_response without cpu_request");
            violations++;
        end

    // a miss is never answered while memory is busy
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        !(memory_request && cpu_response))
        else begin
            $error("memory_request and cpu_response high together");
            violations++;
        end

    // quiet outputs after reset
    a_reset_low: assert property (@(posedge clk)
        rst |=> !cpu_response && !memory_request)
        else begin
            $error("cpu_response or memory_request high after reset");
            violations++;
        end

endmodule

bind cache cache_assert u_cache_assert (
    .clk             (clk),
    .rst             (rst),
    .cpu_request     (cpu_request),
    .cpu_response    (cpu_response),
    .memory_request  (memory_request),
    .memory_response (memory_response)
);

// ==== tests/cache_checker.sv ====
`timescale 1ns/1ns
`include "cache_defs.svh"

// watches the cache ports, compares against a shadow memory
// and a shadow two-way lru tag model
module cache_checker (
    input  logic                  clk,
    input  logic                  rst,
    // current table entry
    input  int                    test_id,
    input  int                    entry_id,
    input  logic                  expect_hit,
    // cpu side
    input  logic                  cpu_request,
    input  logic                  cpu_rw,
    input  logic [`ADDR_BITS-1:0] cpu_addr,
    input  cache_pkg::word_t      cpu_wdata,
    input  cache_pkg::word_t      cpu_rdata,
    input  logic                  cpu_response,
    // memory side
    input  logic                  memory_request,
    input  logic                  memory_rw,
    input  cache_pkg::mem_xfer_t  mem_out,
    // totals
    output int                    pass_count,
    output int                    fail_count
);

    import cache_pkg::*;

    localparam int SETS = 1 << `SET_BITS;

    // cpu-visible value of every written word, by word address
    word_t shadow [int];

    // slot 0 most recently used, slot 1 next victim
    logic [`TAG_BITS-1:0] m_tag   [SETS][2];
    logic                 m_valid [SETS][2];
    logic                 m_dirty [SETS][2];

    // memory traffic seen during the current access
    logic saw_wb;
    logic saw_rd;
    logic mreq_q;
    logic bad;
    // cycles the current request has waited so far
    int   req_cycles;

    // memory pattern of a word never written
    function automatic word_t pattern_word(input logic [`ADDR_BITS-3:0] wa);
        return {wa, 4'ha, wa};
    endfunction

    function automatic word_t view_word(input logic [`ADDR_BITS-3:0] wa);
        if (shadow.exists(int'(wa))) begin
            return shadow[int'(wa)];
        end
        return pattern_word(wa);
    endfunction

    // whole line as the cpu would read it
    function automatic line_t view_line(input logic [`ADDR_BITS-1:0] la);
        line_t                 l;
        logic [`ADDR_BITS-3:0] wa;
        for (int i = 0; i < `LINE_WORDS; i++) begin
            wa = {la[`ADDR_BITS-1:`OFFSET_BITS], 2'(i)};
            l[i*`WORD_BITS +: `WORD_BITS] = view_word(wa);
        end
        return l;
    endfunction

    task automatic flag_error(input string msg);
        $display("FAILED at %0t: test %0d entry %0d, %s", $time, test_id, entry_id, msg);
        bad = 1'b1;
    endtask

    always @(posedge clk) begin
        logic [`SET_BITS-1:0]  s;
        logic [`TAG_BITS-1:0]  t;
        logic [`ADDR_BITS-1:0] line_addr;
        logic [`ADDR_BITS-1:0] victim;
        logic                  victim_dirty;
        logic                  obs_hit;
        logic                  new_dirty;
        int                    pos;
        s = cpu_addr[`OFFSET_BITS +: `SET_BITS];
        t = cpu_addr[`ADDR_BITS-1 -: `TAG_BITS];
        line_addr = cpu_addr;
        line_addr[`OFFSET_BITS-1:0] = '0;
        // victim line address from the model
        victim = line_addr;
        victim[`ADDR_BITS-1 -: `TAG_BITS] = m_tag[s][1];
        victim_dirty = m_valid[s][1] && m_dirty[s][1];
        if (rst) begin
            saw_wb = 1'b0;
            saw_rd = 1'b0;
            mreq_q = 1'b0;
            bad = 1'b0;
            req_cycles = 0;
            pass_count = 0;
            fail_count = 0;
            for (int i = 0; i < SETS; i++) begin
                for (int j = 0; j < 2; j++) begin
                    m_valid[i][j] = 1'b0;
                    m_dirty[i][j] = 1'b0;
                    m_tag[i][j] = '0;
                end
            end
        end else begin
            // start of a memory transfer
            if (memory_request && !mreq_q) begin
                if (memory_rw) begin
                    saw_wb = 1'b1;
                    if (!victim_dirty || mem_out.addr != victim) begin
                        flag_error($sformatf("write-back to 0x%h, victim 0x%h dirty %0b",
                            mem_out.addr, victim, victim_dirty));
                    end else if (mem_out.line != view_line(victim)) begin
                        flag_error($sformatf("write-back line 0x%h, expected 0x%h",
                            mem_out.line, view_line(victim)));
                    end
                end else begin
                    saw_rd = 1'b1;
                    if (mem_out.addr != line_addr) begin
                        flag_error($sformatf("line read at 0x%h, expected 0x%h",
                            mem_out.addr, line_addr));
                    end
                    // dirty victim leaves first
                    if (victim_dirty && !saw_wb) begin
                        flag_error("line read before write-back of the dirty victim");
                    end
                end
            end
            mreq_q = memory_request;

            // access finished
            if (cpu_request && cpu_response) begin
                pos = -1;
                for (int i = 0; i < 2; i++) begin
                    if (m_valid[s][i] && m_tag[s][i] == t) begin
                        pos = i;
                    end
                end
                obs_hit = !saw_rd && !saw_wb;
                if (obs_hit != expect_hit) begin
                    flag_error($sformatf("hit %0b, table expects %0b", obs_hit, expect_hit));
                end
                if (obs_hit != (pos >= 0)) begin
                    flag_error($sformatf("hit %0b, lru model expects %0b", obs_hit, pos >= 0));
                end
                // a hit answers in the cycle of the request
                if (obs_hit && req_cycles != 0) begin
                    flag_error($sformatf("hit answered after %0d cycles, expected 0",
                        req_cycles));
                end
                if (!obs_hit && !saw_rd) begin
                    flag_error("miss finished without a line read");
                end
                if (saw_wb != (pos < 0 && victim_dirty)) begin
                    flag_error($sformatf("write-back seen %0b, expected %0b",
                        saw_wb, pos < 0 && victim_dirty));
                end
                if (!cpu_rw && cpu_rdata != view_word(cpu_addr[`ADDR_BITS-1:2])) begin
                    flag_error($sformatf("read 0x%h, expected 0x%h",
                        cpu_rdata, view_word(cpu_addr[`ADDR_BITS-1:2])));
                end
                if (cpu_rw) begin
                    shadow[int'(cpu_addr[`ADDR_BITS-1:2])] = cpu_wdata;
                end
                // touched or filled tag moves to slot 0
                if (pos != 0) begin
                    new_dirty = (pos == 1) ? m_dirty[s][1] : 1'b0;
                    m_tag[s][1] = m_tag[s][0];
                    m_valid[s][1] = m_valid[s][0];
                    m_dirty[s][1] = m_dirty[s][0];
                    m_tag[s][0] = t;
                    m_valid[s][0] = 1'b1;
                    m_dirty[s][0] = new_dirty;
                end
                m_dirty[s][0] = m_dirty[s][0] | cpu_rw;
                if (bad) begin
                    fail_count++;
                end else begin
                    pass_count++;
                end
                $display("test %0d entry %0d: %s", test_id, entry_id, bad ? "mismatch" : "ok");
                saw_wb = 1'b0;
                saw_rd = 1'b0;
                bad = 1'b0;
                req_cycles = 0;
            end else if (cpu_request) begin
                req_cycles++;
            end
        end
    end

endmodule

// ==== tests/cache_tb.sv ====
`timescale 1ns/1ns
`include "cache_defs.svh"

// cpu stimulus and memory model around the cache
module cache_tb;

    import cache_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int NUM_STIM       = 23;

    // one cpu access, rw high for a write
    typedef struct packed {
        logic                  rw;
        logic [`ADDR_BITS-1:0] addr;
        word_t                 wdata;
        logic [7:0]            test;
        logic                  hit;
    } stim_t;

    // set 2 tags at 0x0120/0x0220/0x0320, set 5 at 0x?50, set 7 at 0x?70
    localparam stim_t STIM [NUM_STIM] = '{
        '{1'b0, 16'h0120, 32'h0000_0000, 8'd1, 1'b0},
        '{1'b0, 16'h0124, 32'h0000_0000, 8'd2, 1'b1},
        '{1'b0, 16'h0120, 32'h0000_0000, 8'd2, 1'b1},
        '{1'b1, 16'h0128, 32'hdead_beef, 8'd3, 1'b1},
        '{1'b0, 16'h0128, 32'h0000_0000, 8'd3, 1'b1},
        '{1'b0, 16'h012c, 32'h0000_0000, 8'd3, 1'b1},
        '{1'b0, 16'h0124, 32'h0000_0000, 8'd3, 1'b1},
        '{1'b0, 16'h0050, 32'h0000_0000, 8'd4, 1'b0},
        '{1'b0, 16'h0150, 32'h0000_0000, 8'd4, 1'b0},
        '{1'b0, 16'h0050, 32'h0000_0000, 8'd4, 1'b1},
        '{1'b0, 16'h0250, 32'h0000_0000, 8'd4, 1'b0},
        '{1'b0, 16'h0058, 32'h0000_0000, 8'd4, 1'b1},
        '{1'b0, 16'h0150, 32'h0000_0000, 8'd4, 1'b0},
        '{1'b0, 16'h0054, 32'h0000_0000, 8'd4, 1'b1},
        '{1'b1, 16'h0220, 32'h1234_5678, 8'd5, 1'b0},
        '{1'b0, 16'h0320, 32'h0000_0000, 8'd5, 1'b0},
        '{1'b0, 16'h0128, 32'h0000_0000, 8'd5, 1'b0},
        '{1'b0, 16'h0220, 32'h0000_0000, 8'd5, 1'b0},
        '{1'b0, 16'h0124, 32'h0000_0000, 8'd5, 1'b1},
        '{1'b0, 16'h0070, 32'h0000_0000, 8'd6, 1'b0},
        '{1'b0, 16'h0170, 32'h0000_0000, 8'd6, 1'b0},
        '{1'b0, 16'h0270, 32'h0000_0000, 8'd6, 1'b0},
        '{1'b0, 16'h0074, 32'h0000_0000, 8'd6, 1'b0}
    };

    logic                  clk = 1'b0;
    logic                  rst = 1'b1;
    // cpu side
    logic                  cpu_request = 1'b0;
    logic                  cpu_rw = 1'b0;
    logic [`ADDR_BITS-1:0] cpu_addr = '0;
    word_t                 cpu_wdata = '0;
    word_t                 cpu_rdata;
    logic                  cpu_response;
    // memory side
    logic                  memory_request;
    logic                  memory_rw;
    mem_xfer_t             mem_out;
    logic                  memory_response = 1'b0;
    line_t                 memory_rdata = '0;
    // entry under test, for the checker
    int                    test_id = 0;
    int                    entry_id = 0;
    logic                  expect_hit = 1'b0;
    int                    pass_count;
    int                    fail_count;

    // memory model storage and latency counter
    line_t                 mem_lines [int];
    logic                  mem_busy = 1'b0;
    int unsigned           mem_wait = 0;

    cache u_cache (.*);

    cache_checker u_checker (.*);

    initial begin
        forever #5 clk = ~clk;
    end

    function automatic int line_key(input logic [`ADDR_BITS-1:0] la);
        return int'(la[`ADDR_BITS-1:`OFFSET_BITS]);
    endfunction

    // stored line, or an address pattern for a line never written
    function automatic line_t fetch_line(input logic [`ADDR_BITS-1:0] la);
        line_t                 l;
        logic [`ADDR_BITS-3:0] wa;
        if (mem_lines.exists(line_key(la))) begin
            return mem_lines[line_key(la)];
        end
        for (int i = 0; i < `LINE_WORDS; i++) begin
            wa = {la[`ADDR_BITS-1:`OFFSET_BITS], 2'(i)};
            l[i*`WORD_BITS +: `WORD_BITS] = {wa, 4'ha, wa};
        end
        return l;
    endfunction

    // four-phase memory, random latency
    initial begin
        // latency draws all come from this seed
        void'($urandom(19196));
        forever begin
            @(posedge clk);
            if (rst) begin
                memory_response <= 1'b0;
                mem_busy        <= 1'b0;
            end else if (memory_response) begin
                // held until the request falls
                if (!memory_request) begin
                    memory_response <= 1'b0;
                end
            end else if (mem_busy) begin
                if (mem_wait == 0) begin
                    mem_busy        <= 1'b0;
                    memory_response <= 1'b1;
                    if (memory_rw) begin
                        mem_lines[line_key(mem_out.addr)] = mem_out.line;
                    end else begin
                        memory_rdata <= fetch_line(mem_out.addr);
                    end
                end else begin
                    mem_wait <= mem_wait - 1;
                end
            end else if (memory_request) begin
                mem_busy <= 1'b1;
                mem_wait <= $urandom_range(0, 4);
            end
        end
    end

    initial begin
        int   waited;
        logic timed_out;
        timed_out = 1'b0;
        // reset for 3 cycles
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < NUM_STIM; i++) begin
            @(posedge clk);
            cpu_request <= 1'b1;
            cpu_rw      <= STIM[i].rw;
            cpu_addr    <= STIM[i].addr;
            cpu_wdata   <= STIM[i].wdata;
            test_id     <= int'(STIM[i].test);
            entry_id    <= i;
            expect_hit  <= STIM[i].hit;
            waited = 0;
            // request held until the cache answers
            do begin
                @(posedge clk);
                waited++;
            end while (!cpu_response && waited < TIMEOUT_CYCLES);
            if (!cpu_response) begin
                $display("timeout: the cache never answered test %0d entry %0d",
                    STIM[i].test, i);
                timed_out = 1'b1;
                break;
            end
            cpu_request <= 1'b0;
        end
        if (timed_out) begin
            $display("Result: FAILED");
        end else begin
            // let the checker count the last access
            @(posedge clk);
            $display("passed %0d, failed %0d of %0d accesses, %0d assertion failures",
                pass_count, fail_count, NUM_STIM, u_cache.u_cache_assert.violations);
            if (fail_count == 0 && pass_count == NUM_STIM &&
                u_cache.u_cache_assert.violations == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+src
src/cache_pkg.sv
src/set_array.sv
src/cache_control.sv
src/cache_datapath.sv
src/cache.sv
tests/cache_assert.sv
tests/cache_checker.sv
tests/cache_tb.sv
